/* hdl/icache_params.svh */
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Cache geometry
`define ICACHE_SETS      128
`define ICACHE_WAYS      2
`define ICACHE_BANKS     8

// Address split into 20 + 7 + 5 bits
`define ICACHE_TAG_W     20
`define ICACHE_INDEX_W   7
`define ICACHE_OFFSET_W  5

// Data widths
`define ICACHE_WORD_W    32
`define ICACHE_LINE_W    256

`endif

/* hdl/icache_pkg.sv */
`include "icache_params.svh"

package icache_pkg;

    // Processor address layout
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]    tag;
        logic [`ICACHE_INDEX_W-1:0]  index;
        logic [`ICACHE_OFFSET_W-1:0] offset;
    } cache_addr_t;

    // One line as a flat word or as bank words with bank 0 lowest
    typedef union packed {
        logic [`ICACHE_LINE_W-1:0]                       flat;
        logic [`ICACHE_BANKS-1:0][`ICACHE_WORD_W-1:0]    bank;
    } cache_line_t;

    typedef struct packed {
        logic        uncache;
        cache_addr_t addr;
    } cpu_req_t;

    typedef logic way_sel_t;

    typedef struct packed {
        logic way0_hit;
        logic way1_hit;
    } lookup_t;

    typedef enum logic [5:0] {
        IDLE    = 6'b000001,
        LOOKUP  = 6'b000010,
        REPLACE = 6'b000100,
        REFILL  = 6'b001000,
        UREQ    = 6'b010000,
        URESP   = 6'b100000
    } cache_state_t;

endpackage

/* hdl/icache_tag_array.sv */
`timescale 1ns/10ps
`include "icache_params.svh"

module icache_tag_array import icache_pkg::*; (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic [`ICACHE_INDEX_W-1:0] array_index,
    input  logic                       lookup_en,
    input  logic                       fill_en,
    input  way_sel_t                   fill_way,
    input  logic [`ICACHE_TAG_W-1:0]   fill_tag,
    input  logic [`ICACHE_TAG_W-1:0]   cmp_tag,
    output lookup_t                    hits
);

    logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] valid_bits;
    logic [`ICACHE_TAG_W-1:0] tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
    logic [`ICACHE_WAYS-1:0]  rd_valid;
    logic [`ICACHE_TAG_W-1:0] rd_tag [`ICACHE_WAYS];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
        end else if (fill_en) begin
            valid_bits[fill_way][array_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[fill_way][array_index] <= fill_tag;
        end
    end

    // Read both ways when a request is accepted
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_valid <= '0;
        end else if (lookup_en) begin
            rd_valid[0] <= valid_bits[0][array_index];
            rd_valid[1] <= valid_bits[1][array_index];
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            rd_tag[0] <= tag_mem[0][array_index];
            rd_tag[1] <= tag_mem[1][array_index];
        end
    end

    assign hits.way0_hit = rd_valid[0] & (rd_tag[0] == cmp_tag);
    assign hits.way1_hit = rd_valid[1] & (rd_tag[1] == cmp_tag);

endmodule

/* hdl/icache_data_array.sv */
`timescale 1ns/10ps
`include "icache_params.svh"

module icache_data_array import icache_pkg::*; (
    input  logic                            clk,
    input  logic [`ICACHE_INDEX_W-1:0]      array_index,
    input  logic                            lookup_en,
    input  logic                            fill_en,
    input  way_sel_t                        fill_way,
    input  cache_line_t                     fill_line,
    output cache_line_t [`ICACHE_WAYS-1:0]  way_lines
);

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        for (genvar b = 0; b < `ICACHE_BANKS; b++) begin : g_bank
            logic [`ICACHE_WORD_W-1:0] mem [`ICACHE_SETS];
            logic [`ICACHE_WORD_W-1:0] rd_q;

            // Refill writes every bank of the chosen way
            always_ff @(posedge clk) begin
                if (fill_en && (int'(fill_way) == w)) begin
                    mem[array_index] <= fill_line.bank[b];
                end
            end

            always_ff @(posedge clk) begin
                if (lookup_en) begin
                    rd_q <= mem[array_index];
                end
            end

            assign way_lines[w].bank[b] = rd_q;
        end
    end

endmodule

/* hdl/icache_plru.sv */
`timescale 1ns/10ps
`include "icache_params.svh"

module icache_plru import icache_pkg::*; (
    input  logic                       clk,
    input  logic                       resetn,
    input  cache_state_t               state,
    input  logic [`ICACHE_INDEX_W-1:0] index,
    input  lookup_t                    hits,
    output way_sel_t                   victim_way
);

    logic [`ICACHE_SETS-1:0] way0_mru;
    logic [`ICACHE_SETS-1:0] way1_mru;
    logic                    miss;

    assign miss = (state == LOOKUP) & ~hits.way0_hit & ~hits.way1_hit;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            way0_mru <= '0;
            way1_mru <= '0;
        end else if ((state == LOOKUP) && hits.way0_hit) begin
            way0_mru[index] <= 1'b1;
            way1_mru[index] <= 1'b0;
        end else if ((state == LOOKUP) && hits.way1_hit) begin
            way1_mru[index] <= 1'b1;
            way0_mru[index] <= 1'b0;
        end else if (state == REPLACE) begin
            // Line being refilled becomes most recent
            way0_mru[index] <= (victim_way == 1'b0);
            way1_mru[index] <= (victim_way == 1'b1);
        end
    end

    // Victim is way 0 unless way 0 was used last
    always_ff @(posedge clk) begin
        if (!resetn) begin
            victim_way <= 1'b0;
        end else if (miss) begin
            victim_way <= way0_mru[index];
        end
    end

endmodule

/* hdl/icache_ctrl.sv */
`timescale 1ns/10ps
`include "icache_params.svh"

module icache_ctrl import icache_pkg::*; (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            valid,
    input  logic                            uncache,
    input  cache_addr_t                     addr,
    input  lookup_t                         hits,
    input  way_sel_t                        victim_way,
    input  cache_line_t [`ICACHE_WAYS-1:0]  way_lines,
    input  logic                            rd_rdy,
    input  logic                            ret_valid,
    input  cache_line_t                     ret_data,
    output logic                            addr_ok,
    output logic                            data_ok,
    output cache_line_t                     rdata,
    output logic [3:0]                      rnum,
    output logic                            rd_req,
    output logic                            rd_type,
    output cache_addr_t                     rd_addr,
    output logic                            lookup_en,
    output logic [`ICACHE_INDEX_W-1:0]      array_index,
    output logic                            fill_en,
    output way_sel_t                        fill_way,
    output cache_state_t                    state
);

    cpu_req_t     rb;
    cache_state_t next_state;
    cache_line_t  hit_line;
    logic         accept;
    logic         cache_hit;

    assign cache_hit = hits.way0_hit | hits.way1_hit;
    assign addr_ok   = valid & ((state == IDLE) | ((state == LOOKUP) & cache_hit));
    assign accept    = valid & addr_ok;

    always_ff @(posedge clk) begin
        if (accept) begin
            rb.uncache <= uncache;
            rb.addr    <= addr;
        end
    end

    // New request reads the arrays, refill writes the buffered set
    assign lookup_en   = accept & ~uncache;
    assign array_index = accept ? addr.index : rb.addr.index;
    assign fill_en     = (state == REFILL) & ret_valid;
    assign fill_way    = victim_way;

    assign hit_line = hits.way1_hit ? way_lines[1] : way_lines[0];

    assign data_ok = ((state == LOOKUP) & cache_hit) |
                     (((state == REFILL) | (state == URESP)) & ret_valid);

    always_comb begin
        rdata = hit_line;
        if (state == REFILL) begin
            rdata = ret_data;
        end else if (state == URESP) begin
            // Single word goes out in the top bank
            rdata.flat    = '0;
            rdata.bank[7] = ret_data.bank[0];
        end
    end

    assign rnum = rb.uncache ? 4'd1 : 4'd8 - {1'b0, rb.addr.offset[4:2]};

    assign rd_req         = (state == REPLACE) | (state == UREQ);
    assign rd_type        = ~rb.uncache;
    assign rd_addr.tag    = rb.addr.tag;
    assign rd_addr.index  = rb.addr.index;
    assign rd_addr.offset = rb.uncache ? rb.addr.offset : '0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    next_state = uncache ? UREQ : LOOKUP;
                end
            end
            LOOKUP: begin
                if (!cache_hit) begin
                    next_state = REPLACE;
                end else if (accept) begin
                    next_state = uncache ? UREQ : LOOKUP;
                end else begin
                    next_state = IDLE;
                end
            end
            REPLACE: begin
                if (rd_rdy) begin
                    next_state = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid) begin
                    next_state = IDLE;
                end
            end
            UREQ: begin
                if (rd_rdy) begin
                    next_state = URESP;
                end
            end
            URESP: begin
                if (ret_valid) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

endmodule

/* hdl/icache_top.sv */
`timescale 1ns/10ps
`include "icache_params.svh"

module icache_top import icache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    // Processor side
    input  logic        valid,
    input  logic        uncache,
    input  cache_addr_t addr,
    output logic        addr_ok,
    output logic        data_ok,
    output cache_line_t rdata,
    output logic [3:0]  rnum,
    // Memory side
    output logic        rd_req,
    output logic        rd_type,
    output cache_addr_t rd_addr,
    input  logic        rd_rdy,
    input  logic        ret_valid,
    input  cache_line_t ret_data
);

    lookup_t                         hits;
    way_sel_t                        victim_way;
    way_sel_t                        fill_way;
    cache_line_t [`ICACHE_WAYS-1:0]  way_lines;
    logic                            lookup_en;
    logic                            fill_en;
    logic [`ICACHE_INDEX_W-1:0]      array_index;
    cache_state_t                    state;

    icache_ctrl ctrl0 (
        .clk         (clk),
        .resetn      (resetn),
        .valid       (valid),
        .uncache     (uncache),
        .addr        (addr),
        .hits        (hits),
        .victim_way  (victim_way),
        .way_lines   (way_lines),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_data    (ret_data),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .rnum        (rnum),
        .rd_req      (rd_req),
        .rd_type     (rd_type),
        .rd_addr     (rd_addr),
        .lookup_en   (lookup_en),
        .array_index (array_index),
        .fill_en     (fill_en),
        .fill_way    (fill_way),
        .state       (state)
    );

    // Buffered tag and index are carried on rd_addr
    icache_tag_array tags0 (
        .clk         (clk),
        .resetn      (resetn),
        .array_index (array_index),
        .lookup_en   (lookup_en),
        .fill_en     (fill_en),
        .fill_way    (fill_way),
        .fill_tag    (rd_addr.tag),
        .cmp_tag     (rd_addr.tag),
        .hits        (hits)
    );

    icache_data_array data0 (
        .clk         (clk),
        .array_index (array_index),
        .lookup_en   (lookup_en),
        .fill_en     (fill_en),
        .fill_way    (fill_way),
        .fill_line   (ret_data),
        .way_lines   (way_lines)
    );

    icache_plru plru0 (
        .clk         (clk),
        .resetn      (resetn),
        .state       (state),
        .index       (rd_addr.index),
        .hits        (hits),
        .victim_way  (victim_way)
    );

endmodule

/* test/icache_checker.sv */
`timescale 1ns/10ps

module icache_checker import icache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        valid,
    input  logic        uncache,
    input  cache_addr_t addr,
    input  logic        addr_ok,
    input  logic        data_ok,
    input  cache_line_t rdata,
    input  logic [3:0]  rnum,
    input  logic        rd_req,
    input  logic        rd_type,
    input  cache_addr_t rd_addr,
    input  logic        rd_rdy,
    input  logic        exp_miss,
    input  cache_line_t exp_rdata,
    output int          done_count,
    output int          fail_count,
    output int          err_count
);

    typedef struct packed {
        logic [31:0]  id;
        logic         uncache;
        logic [31:0]  addr;
        logic         miss;
        logic [255:0] rdata;
        logic [31:0]  cycle;
        logic         fetched;
        logic [7:0]   errs;
    } pending_t;

    pending_t    q[$];
    pending_t    head;
    pending_t    entry;
    logic [31:0] cycle;
    logic [31:0] accepted;
    logic [31:0] exp_addr;
    logic [3:0]  exp_rnum;

    initial begin
        done_count = 0;
        fail_count = 0;
        err_count  = 0;
        cycle      = 0;
        accepted   = 0;
    end

    // Everything is sampled mid-cycle
    always @(negedge clk) begin
        if (resetn) begin
            cycle = cycle + 1;
            if (rd_req && rd_rdy) begin
                if (q.size() == 0) begin
                    $display("Memory read issued with no request outstanding");
                    err_count = err_count + 1;
                    fail_count = fail_count + 1;
                end else begin
                    head = q[0];
                    exp_addr = head.uncache ? head.addr : {head.addr[31:5], 5'b0};
                    if (!head.miss) begin
                        $display("Test %0d: memory read issued for a hit", head.id);
                        q[0].errs = q[0].errs + 1;
                    end
                    if (rd_type !== ~head.uncache) begin
                        $display("Fail rd_type test %0d: got %h expected %h",
                                 head.id, rd_type, ~head.uncache);
                        q[0].errs = q[0].errs + 1;
                    end
                    if (rd_addr !== exp_addr) begin
                        $display("Fail rd_addr test %0d: got %h expected %h",
                                 head.id, rd_addr, exp_addr);
                        q[0].errs = q[0].errs + 1;
                    end
                    q[0].fetched = 1'b1;
                end
            end
            if (data_ok) begin
                if (q.size() == 0) begin
                    $display("data_ok raised with no request outstanding");
                    err_count = err_count + 1;
                    fail_count = fail_count + 1;
                end else begin
                    head = q.pop_front();
                    exp_rnum = head.uncache ? 4'd1 : 4'd8 - {1'b0, head.addr[4:2]};
                    if (rdata !== head.rdata) begin
                        $display("Fail rdata test %0d: got %h expected %h",
                                 head.id, rdata, head.rdata);
                        head.errs = head.errs + 1;
                    end
                    if (rnum !== exp_rnum) begin
                        $display("Fail rnum test %0d: got %h expected %h",
                                 head.id, rnum, exp_rnum);
                        head.errs = head.errs + 1;
                    end
                    if (head.miss && !head.fetched) begin
                        $display("Test %0d: a miss was answered without a memory read",
                                 head.id);
                        head.errs = head.errs + 1;
                    end
                    if (!head.miss && (cycle != head.cycle + 1)) begin
                        $display("Test %0d: hit answered %0d cycles after acceptance",
                                 head.id, cycle - head.cycle);
                        head.errs = head.errs + 1;
                    end
                    // A waiting request must be taken on the hit cycle
                    if (!head.miss && valid && (addr_ok !== 1'b1)) begin
                        $display("Fail addr_ok test %0d: got %h expected %h",
                                 head.id, addr_ok, 1'b1);
                        head.errs = head.errs + 1;
                    end
                    if (head.errs == 0) begin
                        $display("Test %0d addr %h: ok", head.id, head.addr);
                    end else begin
                        $display("Test %0d addr %h: %0d errors", head.id, head.addr, head.errs);
                        fail_count = fail_count + 1;
                        err_count = err_count + int'(head.errs);
                    end
                    done_count = done_count + 1;
                end
            end
            // Acceptance is pushed after the pop so a hit cycle can take a new request
            if (valid && addr_ok) begin
                accepted = accepted + 1;
                entry = '{id: accepted, uncache: uncache, addr: addr, miss: exp_miss,
                          rdata: exp_rdata, cycle: cycle, fetched: 1'b0, errs: 8'd0};
                q.push_back(entry);
            end
        end
    end

endmodule

/* test/icache_tb.sv */
`timescale 1ns/10ps

module icache_tb import icache_pkg::*; ();

    logic        clk;
    logic        resetn;
    logic        valid;
    logic        uncache;
    cache_addr_t addr;
    logic        addr_ok;
    logic        data_ok;
    cache_line_t rdata;
    logic [3:0]  rnum;
    logic        rd_req;
    logic        rd_type;
    cache_addr_t rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    cache_line_t ret_data;
    logic        exp_miss;
    cache_line_t exp_rdata;
    int          done_count;
    int          fail_count;
    int          err_count;

    logic         t_uncache [64];
    logic [31:0]  t_addr [64];
    logic         t_miss [64];
    logic [255:0] t_line [64];
    logic [255:0] t_exp [64];
    int           n_tests;
    int           seed;

    icache_top dut0 (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .uncache   (uncache),
        .addr      (addr),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rnum      (rnum),
        .rd_req    (rd_req),
        .rd_type   (rd_type),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    icache_checker chk0 (
        .clk        (clk),
        .resetn     (resetn),
        .valid      (valid),
        .uncache    (uncache),
        .addr       (addr),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .rnum       (rnum),
        .rd_req     (rd_req),
        .rd_type    (rd_type),
        .rd_addr    (rd_addr),
        .rd_rdy     (rd_rdy),
        .exp_miss   (exp_miss),
        .exp_rdata  (exp_rdata),
        .done_count (done_count),
        .fail_count (fail_count),
        .err_count  (err_count)
    );

    always #10 clk = ~clk;

    initial begin
        clk       = 1'b0;
        resetn    = 1'b0;
        valid     = 1'b0;
        uncache   = 1'b0;
        addr      = '0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        exp_miss  = 1'b0;
        exp_rdata = '0;
        seed      = 15067;
        n_tests   = 0;
    end

    task automatic load_tests();
        int           fd;
        int           cnt;
        string        line;
        logic         u;
        logic         m;
        logic [31:0]  a;
        logic [255:0] l;
        logic [255:0] e;
        fd = $fopen("test/icache_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open test/icache_tests.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 8 && line[0] != "#") begin
                cnt = $sscanf(line, "%h %h %h %h %h", u, a, m, l, e);
                if (cnt == 5 && n_tests < 64) begin
                    t_uncache[n_tests] = u;
                    t_addr[n_tests] = a;
                    t_miss[n_tests] = m;
                    t_line[n_tests] = l;
                    t_exp[n_tests] = e;
                    n_tests = n_tests + 1;
                end
            end
        end
        $fclose(fd);
    endtask

    // Memory model serves the rows that miss in file order
    initial begin
        int delay;
        int ptr;
        ptr = 0;
        forever begin
            @(posedge clk);
            #2;
            if (resetn && rd_req) begin
                delay = $random(seed) & 32'h3;
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                rd_rdy = 1'b1;
                @(posedge clk);
                #2;
                while (ptr < n_tests && !t_miss[ptr]) begin
                    ptr = ptr + 1;
                end
                rd_rdy    = 1'b0;
                ret_valid = 1'b1;
                ret_data  = (ptr < n_tests) ? t_line[ptr] : '0;
                ptr = ptr + 1;
                @(posedge clk);
                #2;
                ret_valid = 1'b0;
            end
        end
    end

    initial begin
        #1;
        #(n_tests * 400 + 1000);
        $display("Timeout: %0d of %0d requests answered", done_count, n_tests);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        #0;
        load_tests();
        repeat (2) @(posedge clk);
        #2;
        resetn = 1'b1;
        // Next request is presented right after acceptance so hits stream
        for (int i = 0; i < n_tests; i++) begin
            valid     = 1'b1;
            uncache   = t_uncache[i];
            addr      = t_addr[i];
            exp_miss  = t_miss[i];
            exp_rdata = t_exp[i];
            @(negedge clk);
            while (!addr_ok) begin
                @(negedge clk);
            end
            @(posedge clk);
            #2;
        end
        valid = 1'b0;
        wait (done_count == n_tests);
        @(negedge clk);
        $display("Tests %0d, failed %0d, errors %0d", done_count, fail_count, err_count);
        if (n_tests > 0 && fail_count == 0 && err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+hdl
hdl/icache_pkg.sv
hdl/icache_tag_array.sv
hdl/icache_data_array.sv
hdl/icache_plru.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
test/icache_checker.sv
test/icache_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing -f sim.f --top-module icache_tb -o icache_sim > build.log 2>&1 &&
./obj_dir/icache_sim > sim.log 2>&1 ||
echo "Build or simulation error, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -F -q "*** PASSED ***" sim.log 2>/dev/null && echo "Result: pass" && exit 0 ||
{ echo "Result: fail"; exit 1; }

/* test/icache_tests.txt */
# uncache  addr  miss  line returned by memory (256 bits)  expected rdata (256 bits)
# index 0 holds tags 1, 2 and 3 in turn; index 1 takes tag 5
0 00001004 1 a0000007a0000006a0000005a0000004a0000003a0000002a0000001a0000000 a0000007a0000006a0000005a0000004a0000003a0000002a0000001a0000000
0 00001010 0 a0000007a0000006a0000005a0000004a0000003a0000002a0000001a0000000 a0000007a0000006a0000005a0000004a0000003a0000002a0000001a0000000
0 00002000 1 b0000007b0000006b0000005b0000004b0000003b0000002b0000001b0000000 b0000007b0000006b0000005b0000004b0000003b0000002b0000001b0000000
0 0000101c 0 a0000007a0000006a0000005a0000004a0000003a0000002a0000001a0000000 a0000007a0000006a0000005a0000004a0000003a0000002a0000001a0000000
0 00002008 0 b0000007b0000006b0000005b0000004b0000003b0000002b0000001b0000000 b0000007b0000006b0000005b0000004b0000003b0000002b0000001b0000000
0 00003000 1 c0000007c0000006c0000005c0000004c0000003c0000002c0000001c0000000 c0000007c0000006c0000005c0000004c0000003c0000002c0000001c0000000
0 00002004 0 b0000007b0000006b0000005b0000004b0000003b0000002b0000001b0000000 b0000007b0000006b0000005b0000004b0000003b0000002b0000001b0000000
0 00001000 1 a0000007a0000006a0000005a0000004a0000003a0000002a0000001a0000000 a0000007a0000006a0000005a0000004a0000003a0000002a0000001a0000000
0 00002014 0 b0000007b0000006b0000005b0000004b0000003b0000002b0000001b0000000 b0000007b0000006b0000005b0000004b0000003b0000002b0000001b0000000
1 00005024 1 00000000000000000000000000000000000000000000000000000000deadbeef deadbeef00000000000000000000000000000000000000000000000000000000
0 00005020 1 d0000007d0000006d0000005d0000004d0000003d0000002d0000001d0000000 d0000007d0000006d0000005d0000004d0000003d0000002d0000001d0000000
0 00005030 0 d0000007d0000006d0000005d0000004d0000003d0000002d0000001d0000000 d0000007d0000006d0000005d0000004d0000003d0000002d0000001d0000000
0 00001008 0 a0000007a0000006a0000005a0000004a0000003a0000002a0000001a0000000 a0000007a0000006a0000005a0000004a0000003a0000002a0000001a0000000
0 00002018 0 b0000007b0000006b0000005b0000004b0000003b0000002b0000001b0000000 b0000007b0000006b0000005b0000004b0000003b0000002b0000001b0000000
0 0000503c 0 d0000007d0000006d0000005d0000004d0000003d0000002d0000001d0000000 d0000007d0000006d0000005d0000004d0000003d0000002d0000001d0000000
0 00001000 0 a0000007a0000006a0000005a0000004a0000003a0000002a0000001a0000000 a0000007a0000006a0000005a0000004a0000003a0000002a0000001a0000000
